//--- Bender.yml
package:
  name: board_ctrl

sources:
  # shared constants first
  - hdl/board_pkg.sv
  # rtl
  - hdl/tick_timer.sv
  - hdl/led_blinker.sv
  - hdl/ctrl_regs.sv
  - hdl/board_ctrl_top.sv
  # testbench
  - target: simulation
    files:
      - testbench/tb_board_ctrl.sv

//--- hdl/board_ctrl_top.sv
/*
 * board bring-up controller top level
 * register slave, timebase and debug LED blinker
 */
`timescale 1ns/1ns

module board_ctrl_top import board_pkg::*; (
    input  logic                       clk20_g,
    input  logic                       rst_n,
    // wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [reg_addr_w-1:0]      wb_adr,
    input  logic [wb_data_w-1:0]       wb_dat_w,
    output logic [wb_data_w-1:0]       wb_dat_r,
    output logic                       wb_ack,
    // link status from transceiver
    input  logic                       link_tx_lock,
    input  logic                       link_lane_up,
    input  logic                       link_channel_up,
    input  logic                       link_frame_err,
    input  logic                       link_hard_err,
    input  logic                       link_soft_err,
    // link control to transceiver
    output logic                       link_gt_rst,
    output logic                       link_rst,
    output logic [ctrl_loopback_w-1:0] link_loopback,
    output logic                       link_power_down,
    // debug
    output logic                       dbg_led
);

    // ----------------------------------------
    // internal wiring
    // ----------------------------------------
    logic               tick_ms;
    logic [blink_w-1:0] blink_half_ms;
    logic               led_state;

    // us strobe only feeds the ms count inside the timer
    tick_timer u_tick (
        .clk20_g (clk20_g),
        .rst_n   (rst_n),
        .tick_us (),
        .tick_ms (tick_ms)
    );

    ctrl_regs u_regs (
        .clk20_g         (clk20_g),
        .rst_n           (rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack),
        .link_tx_lock    (link_tx_lock),
        .link_lane_up    (link_lane_up),
        .link_channel_up (link_channel_up),
        .link_frame_err  (link_frame_err),
        .link_hard_err   (link_hard_err),
        .link_soft_err   (link_soft_err),
        .link_gt_rst     (link_gt_rst),
        .link_rst        (link_rst),
        .link_loopback   (link_loopback),
        .link_power_down (link_power_down),
        .blink_half_ms   (blink_half_ms)
    );

    led_blinker u_blink (
        .clk20_g       (clk20_g),
        .rst_n         (rst_n),
        .tick_ms       (tick_ms),
        .blink_half_ms (blink_half_ms),
        .led           (led_state)
    );

    // ----------------------------------------
    // debug LED
    // ----------------------------------------
    // dark while transceiver held in reset
    assign dbg_led = led_state & ~link_gt_rst;

endmodule

//--- hdl/board_pkg.sv
/*
 * board bring-up controller shared constants
 * timebase, register map, CTRL and STATUS bit layout
 */
package board_pkg;

    // ----------------------------------------
    // timebase
    // ----------------------------------------
    // clk20_g cycles in one microsecond
    localparam int clks_per_us = 20;
    localparam int us_per_ms   = 1000;
    localparam int cyc_cnt_w   = $clog2(clks_per_us);
    localparam int us_cnt_w    = $clog2(us_per_ms);
    // terminal counts of the two dividers
    localparam logic [cyc_cnt_w-1:0] cyc_last = cyc_cnt_w'(clks_per_us - 1);
    localparam logic [us_cnt_w-1:0]  us_last  = us_cnt_w'(us_per_ms - 1);

    // ----------------------------------------
    // wishbone register map
    // ----------------------------------------
    localparam int wb_data_w  = 32;
    localparam int reg_addr_w = 2;
    localparam logic [reg_addr_w-1:0] reg_ctrl   = 2'd0;
    localparam logic [reg_addr_w-1:0] reg_blink  = 2'd1;
    localparam logic [reg_addr_w-1:0] reg_status = 2'd2;
    localparam logic [reg_addr_w-1:0] reg_id     = 2'd3;

    // blink half-period in ms
    localparam int blink_w = 16;
    localparam logic [blink_w-1:0]   blink_default_ms = 16'd125;
    localparam logic [wb_data_w-1:0] board_id         = 32'h4C4E4B31;

    // CTRL layout, bits 0..5 implemented
    localparam int ctrl_w              = 6;
    localparam int ctrl_gt_rst_bit     = 0;
    localparam int ctrl_link_rst_bit   = 1;
    localparam int ctrl_loopback_lsb   = 2;
    localparam int ctrl_loopback_w     = 3;
    localparam int ctrl_power_down_bit = 5;

    // STATUS live bits
    localparam int stat_tx_lock_bit    = 0;
    localparam int stat_lane_up_bit    = 1;
    localparam int stat_channel_up_bit = 2;
    // STATUS sticky bits, write one to clear
    localparam int stat_frame_err_bit  = 8;
    localparam int stat_hard_err_bit   = 9;
    localparam int stat_soft_err_bit   = 10;

endpackage

//--- hdl/ctrl_regs.sv
/*
 * Wishbone classic register slave: CTRL, BLINK, STATUS and ID
 * drives link control lines and captures synchronized link status
 */
`timescale 1ns/1ns

module ctrl_regs import board_pkg::*; (
    input  logic                       clk20_g,
    input  logic                       rst_n,
    // wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [reg_addr_w-1:0]      wb_adr,
    input  logic [wb_data_w-1:0]       wb_dat_w,
    output logic [wb_data_w-1:0]       wb_dat_r,
    output logic                       wb_ack,
    // link status
    input  logic                       link_tx_lock,
    input  logic                       link_lane_up,
    input  logic                       link_channel_up,
    input  logic                       link_frame_err,
    input  logic                       link_hard_err,
    input  logic                       link_soft_err,
    // link control
    output logic                       link_gt_rst,
    output logic                       link_rst,
    output logic [ctrl_loopback_w-1:0] link_loopback,
    output logic                       link_power_down,
    // blinker period
    output logic [blink_w-1:0]         blink_half_ms
);

    // ----------------------------------------
    // status synchronizer
    // ----------------------------------------
    // {soft, hard, frame, channel, lane, tx_lock}
    logic [5:0] link_in;
    logic [5:0] sync_q1;
    logic [5:0] sync_q2;
    logic [2:0] live;
    logic [2:0] err;

    assign link_in = {link_soft_err, link_hard_err, link_frame_err,
                      link_channel_up, link_lane_up, link_tx_lock};

    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= link_in;
            sync_q2 <= sync_q1;
        end
    end

    assign live = sync_q2[2:0];
    // {soft, hard, frame}
    assign err  = sync_q2[5:3];

    // ----------------------------------------
    // bus access
    // ----------------------------------------
    logic acc;
    logic wr_en;
    logic [ctrl_w-1:0]  ctrl_q;
    logic [blink_w-1:0] blink_q;
    // {soft, hard, frame}
    logic [2:0] sticky_q;
    logic [2:0] sticky_clr;
    logic [wb_data_w-1:0] rd_data;

    // new cycle, ack not yet given
    assign acc   = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = acc && wb_we;

    // single-cycle ack, dropped while master releases stb
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= acc;
        end
    end

    // writes land on the edge that raises ack
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            ctrl_q  <= '0;
            blink_q <= blink_default_ms;
        end else if (wr_en) begin
            if (wb_adr == reg_ctrl) begin
                ctrl_q <= wb_dat_w[ctrl_w-1:0];
            end
            if (wb_adr == reg_blink) begin
                blink_q <= wb_dat_w[blink_w-1:0];
            end
        end
    end

    // write one to clear, only via STATUS
    always_comb begin
        sticky_clr = '0;
        if (wr_en && (wb_adr == reg_status)) begin
            sticky_clr = {wb_dat_w[stat_soft_err_bit],
                          wb_dat_w[stat_hard_err_bit],
                          wb_dat_w[stat_frame_err_bit]};
        end
    end

    // error seen high wins over clear in the same cycle
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            sticky_q <= '0;
        end else begin
            sticky_q <= (sticky_q & ~sticky_clr) | err;
        end
    end

    // read mux
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            reg_ctrl:  rd_data[ctrl_w-1:0]  = ctrl_q;
            reg_blink: rd_data[blink_w-1:0] = blink_q;
            reg_status: begin
                rd_data[stat_tx_lock_bit]    = live[0];
                rd_data[stat_lane_up_bit]    = live[1];
                rd_data[stat_channel_up_bit] = live[2];
                rd_data[stat_frame_err_bit]  = sticky_q[0];
                rd_data[stat_hard_err_bit]   = sticky_q[1];
                rd_data[stat_soft_err_bit]   = sticky_q[2];
            end
            reg_id:    rd_data = board_id;
            default:   rd_data = '0;
        endcase
    end

    // read data held with ack
    always_ff @(posedge clk20_g) begin
        if (acc) begin
            wb_dat_r <= rd_data;
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign link_gt_rst     = ctrl_q[ctrl_gt_rst_bit];
    assign link_rst        = ctrl_q[ctrl_link_rst_bit];
    assign link_loopback   = ctrl_q[ctrl_loopback_lsb +: ctrl_loopback_w];
    assign link_power_down = ctrl_q[ctrl_power_down_bit];
    assign blink_half_ms   = blink_q;

endmodule

//--- hdl/led_blinker.sv
/*
 * LED blinker: toggles the LED every blink_half_ms millisecond strobes
 * period zero holds the LED low
 */
`timescale 1ns/1ns

module led_blinker import board_pkg::*; (
    input  logic               clk20_g,
    input  logic               rst_n,
    input  logic               tick_ms,
    input  logic [blink_w-1:0] blink_half_ms,
    output logic               led
);

    // ms strobes since last toggle
    logic [blink_w-1:0] ms_cnt;
    // period seen on the previous cycle
    logic [blink_w-1:0] period_q;

    logic period_chg;
    logic period_zero;
    logic half_done;

    assign period_chg  = (blink_half_ms != period_q);
    assign period_zero = (blink_half_ms == '0);
    // this strobe completes the half-period
    assign half_done   = tick_ms && !period_zero && (ms_cnt == blink_half_ms - 1'b1);

    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            ms_cnt   <= '0;
            period_q <= '0;
            led      <= 1'b0;
        end else begin
            period_q <= blink_half_ms;
            if (period_chg) begin
                // new period, count restarts from this cycle
                ms_cnt <= '0;
            end else if (half_done) begin
                ms_cnt <= '0;
                led    <= ~led;
            end else if (tick_ms && !period_zero) begin
                ms_cnt <= ms_cnt + 1'b1;
            end
            // stopped blinker parks the LED off
            if (period_zero) begin
                led <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/tick_timer.sv
/*
 * timebase: one-cycle microsecond and millisecond strobes
 * derived from clk20_g by two cascaded wrap counters
 */
`timescale 1ns/1ns

module tick_timer import board_pkg::*; (
    input  logic clk20_g,
    input  logic rst_n,
    output logic tick_us,
    output logic tick_ms
);

    // ----------------------------------------
    // counters
    // ----------------------------------------
    // clock cycles inside the current microsecond
    logic [cyc_cnt_w-1:0] cyc_cnt;
    // microseconds inside the current millisecond
    logic [us_cnt_w-1:0]  us_cnt;

    // wrap conditions
    logic us_wrap;
    logic ms_wrap;

    // last cycle of a microsecond
    assign us_wrap = (cyc_cnt == cyc_last);
    // last cycle of the last microsecond of a millisecond
    assign ms_wrap = us_wrap && (us_cnt == us_last);

    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            cyc_cnt <= '0;
        end else if (us_wrap) begin
            cyc_cnt <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // advances only on the microsecond wrap
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            us_cnt <= '0;
        end else if (ms_wrap) begin
            us_cnt <= '0;
        end else if (us_wrap) begin
            us_cnt <= us_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // strobes
    // ----------------------------------------
    // registered, one clk wide
    // tick_us every 20 cycles, tick_ms on every 1000th tick_us
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            tick_us <= 1'b0;
            tick_ms <= 1'b0;
        end else begin
            tick_us <= us_wrap;
            tick_ms <= ms_wrap;
        end
    end

endmodule

//--- sim.f
hdl/board_pkg.sv
hdl/tick_timer.sv
hdl/led_blinker.sv
hdl/ctrl_regs.sv
hdl/board_ctrl_top.sv
testbench/tb_board_ctrl.sv

//--- testbench/tb_board_ctrl.sv
/*
 * directed testbench for the board bring-up controller
 * wishbone register access, status capture, blink timing, LED gating
 */
`timescale 1ns/1ns

module tb_board_ctrl import board_pkg::*; ();

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic                       clk20_g;
    logic                       rst_n;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [reg_addr_w-1:0]      wb_adr;
    logic [wb_data_w-1:0]       wb_dat_w;
    logic [wb_data_w-1:0]       wb_dat_r;
    logic                       wb_ack;
    logic                       link_tx_lock;
    logic                       link_lane_up;
    logic                       link_channel_up;
    logic                       link_frame_err;
    logic                       link_hard_err;
    logic                       link_soft_err;
    logic                       link_gt_rst;
    logic                       link_rst;
    logic [ctrl_loopback_w-1:0] link_loopback;
    logic                       link_power_down;
    logic                       dbg_led;

    // about 210k cycles of tests plus margin
    localparam int max_cycles = 400000;
    // one millisecond in clk20_g cycles
    localparam int ms_cycles  = clks_per_us * us_per_ms;

    int          err_cnt   = 0;
    int          chk_cnt   = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng       = 32'd64721;

    board_ctrl_top dut0 (.*);

    // 8 ns clock
    initial begin
        clk20_g = 1'b0;
        forever #4 clk20_g = ~clk20_g;
    end

    // watchdog
    always @(posedge clk20_g) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // n edges, then 1 ns past the last one
    task automatic step(input int n);
        repeat (n) @(posedge clk20_g);
        #1;
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // ack within 10 cycles, then release the bus for a cycle
    task automatic finish_access(input string what);
        int n;
        n = 0;
        do begin
            step(1);
            n++;
        end while (!wb_ack && n < 10);
        if (!wb_ack) begin
            $display("bus error: %s got no wb_ack within 10 cycles", what);
            err_cnt++;
        end
    endtask

    task automatic wb_write(input logic [reg_addr_w-1:0] adr, input logic [31:0] dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        finish_access($sformatf("write to register %0d", adr));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step(1);
    endtask

    task automatic wb_read(input logic [reg_addr_w-1:0] adr, output logic [31:0] dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        finish_access($sformatf("read of register %0d", adr));
        // data valid alongside ack
        dat    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        step(1);
    endtask

    // cycles until dbg_led next changes
    task automatic wait_led_change(input int limit, output int cycles);
        logic prev;
        prev   = dbg_led;
        cycles = 0;
        while (dbg_led === prev && cycles < limit) begin
            step(1);
            cycles++;
        end
        if (dbg_led === prev) begin
            $display("dbg_led did not change within %0d cycles", limit);
            err_cnt++;
        end
    endtask

    task automatic hold_led_low(input int cycles, input string what);
        int bad;
        bad = 0;
        for (int i = 0; i < cycles; i++) begin
            if (dbg_led !== 1'b0 && bad == 0) begin
                $display("FAIL @%0t: dbg_led high during %s", $time, what);
                bad = 1;
                err_cnt++;
            end
            step(1);
        end
        chk_cnt++;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_defaults();
        logic [31:0] rd;
        expect_eq("wb_ack after reset", wb_ack, 0);
        expect_eq("control outputs after reset",
                  {link_gt_rst, link_rst, link_loopback, link_power_down}, 0);
        expect_eq("dbg_led after reset", dbg_led, 0);
        wb_read(reg_ctrl, rd);
        expect_eq("CTRL reset value", rd, 0);
        wb_read(reg_blink, rd);
        expect_eq("BLINK reset value", rd, 125);
        wb_read(reg_id, rd);
        expect_eq("ID value", rd, 32'h4C4E4B31);
    endtask

    task automatic ctrl_mapping();
        logic [31:0] val;
        logic [31:0] rd;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            val = rng;
            wb_write(reg_ctrl, val);
            wb_read(reg_ctrl, rd);
            expect_eq("CTRL readback", rd, val & 32'h3F);
            expect_eq("link_gt_rst", link_gt_rst, val[ctrl_gt_rst_bit]);
            expect_eq("link_rst", link_rst, val[ctrl_link_rst_bit]);
            expect_eq("link_loopback", link_loopback, val[ctrl_loopback_lsb +: 3]);
            expect_eq("link_power_down", link_power_down, val[ctrl_power_down_bit]);
        end
        // unimplemented upper bits
        wb_write(reg_ctrl, 32'hFFFF_FFC0);
        wb_read(reg_ctrl, rd);
        expect_eq("CTRL upper bits", rd, 0);
    endtask

    task automatic status_capture();
        logic [31:0] rd;
        logic [2:0]  live_exp;
        logic [31:0] sticky_exp;
        int          err_bits[3];
        err_bits   = '{stat_frame_err_bit, stat_hard_err_bit, stat_soft_err_bit};
        sticky_exp = 0;
        for (int i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            live_exp        = rng[2:0];
            link_tx_lock    = live_exp[0];
            link_lane_up    = live_exp[1];
            link_channel_up = live_exp[2];
            // through the two-stage synchronizer
            step(5);
            wb_read(reg_status, rd);
            expect_eq("STATUS live bits", rd, {29'd0, live_exp});
        end
        // one-cycle error pulses, each must stick
        for (int e = 0; e < 3; e++) begin
            {link_soft_err, link_hard_err, link_frame_err} = 3'b001 << e;
            step(1);
            {link_soft_err, link_hard_err, link_frame_err} = 3'b000;
            step(5);
            sticky_exp[err_bits[e]] = 1'b1;
            wb_read(reg_status, rd);
            expect_eq("STATUS sticky set", rd, sticky_exp | live_exp);
        end
        // write one clears only that bit
        for (int e = 0; e < 3; e++) begin
            wb_write(reg_status, 32'd1 << err_bits[e]);
            sticky_exp[err_bits[e]] = 1'b0;
            wb_read(reg_status, rd);
            expect_eq("STATUS sticky clear", rd, sticky_exp | live_exp);
        end
    endtask

    task automatic blink_timing();
        int gap;
        wb_write(reg_ctrl, 0);
        wb_write(reg_blink, 2);
        // align to a toggle, then measure a full half-period
        wait_led_change(4 * ms_cycles, gap);
        wait_led_change(4 * ms_cycles, gap);
        expect_eq("blink half-period cycles", gap, 2 * ms_cycles);
        // stop while lit so the zero period has to pull it low
        wait_led_change(4 * ms_cycles, gap);
        expect_eq("dbg_led lit before stop", dbg_led, 1);
        wb_write(reg_blink, 0);
        hold_led_low(3 * ms_cycles, "zero blink period");
    endtask

    task automatic led_gating();
        logic [31:0] rd;
        wb_write(reg_blink, 1);
        wb_write(reg_ctrl, 32'd1 << ctrl_gt_rst_bit);
        hold_led_low(30000, "transceiver reset");
        wb_write(reg_id, 32'h0000_0000);
        wb_read(reg_id, rd);
        expect_eq("ID after write", rd, 32'h4C4E4B31);
        wb_write(reg_ctrl, 0);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        rst_n           = 1'b0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        link_tx_lock    = 1'b0;
        link_lane_up    = 1'b0;
        link_channel_up = 1'b0;
        link_frame_err  = 1'b0;
        link_hard_err   = 1'b0;
        link_soft_err   = 1'b0;
        step(2);
        rst_n = 1'b1;
        step(1);

        reset_defaults();
        ctrl_mapping();
        status_capture();
        blink_timing();
        led_gating();

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
